/* common/obj_pkg.sv */
`default_nettype none

package obj_pkg;

    typedef logic [9:0]  entry_idx_t;
    typedef logic [14:0] ram_addr_t;
    typedef logic [15:0] ram_word_t;
    // wraps on overflow, like the scroll arithmetic
    typedef logic [11:0] coord_t;
    typedef logic [7:0]  color_t;
    typedef logic [13:0] tile_code_t;
    typedef logic [3:0]  pixel_t;
    // row in [14:7], column of four pixels in [6:0]
    typedef logic [14:0] fb_addr_t;
    // four pixels of {4'b0, color, pixel}
    typedef logic [63:0] fb_word_t;
    typedef logic [7:0]  fb_be_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_READ_START,
        ST_READ,
        ST_EVAL,
        ST_CHECK,
        ST_TILE_REQ,
        ST_TILE_WAIT,
        ST_DRAW_WAIT,
        ST_DRAW_WRITE
    } obj_state_t;

    // entries placed beyond these are not drawn
    localparam int X_LIMIT = 480;
    localparam int Y_LIMIT = 240;

    localparam int TILE_BEATS = 16;

endpackage

`default_nettype wire

/* logic/obj_pacer.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_pacer #(
    parameter int ENTRY_COUNT = 835,
    parameter int PACE_SHIFT  = 8
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 start,
    input  wire                 next,
    output obj_pkg::entry_idx_t entry_idx,
    output logic                entry_go,
    output logic                list_end
);

    // one spare top bit so the count can saturate past the last entry
    localparam int CW = $clog2(ENTRY_COUNT + 1) + PACE_SHIFT + 1;

    logic [CW-1:0] cycle_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= '0;
            entry_idx <= '0;
        end else if (start) begin
            cycle_cnt <= '0;
            entry_idx <= '0;
        end else begin
            if (!cycle_cnt[CW-1]) begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
            if (next) begin
                entry_idx <= entry_idx + 1'b1;
            end
        end
    end

    // entry n may start from cycle n << PACE_SHIFT
    assign entry_go = (cycle_cnt >> PACE_SHIFT) >= CW'(entry_idx);
    assign list_end = entry_idx == obj_pkg::entry_idx_t'(ENTRY_COUNT);

endmodule

`default_nettype wire

/* obj/obj_entry_eval.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_entry_eval (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              eval,
    input  wire                              check,
    input  wire obj_pkg::ram_word_t [7:0]    entry_words,
    output obj_pkg::coord_t                  pos_x,
    output obj_pkg::coord_t                  pos_y,
    output obj_pkg::color_t                  color,
    output logic                             flip_x,
    output obj_pkg::tile_code_t              tile_code,
    output logic                             in_bounds
);

    obj_pkg::ram_word_t w4;
    obj_pkg::ram_word_t w6;
    obj_pkg::coord_t    in_x, in_y;
    obj_pkg::coord_t    master_x, master_y;
    obj_pkg::coord_t    extra_x, extra_y;
    obj_pkg::coord_t    base_x, base_y;
    obj_pkg::coord_t    scroll_x, scroll_y;
    obj_pkg::coord_t    base_x_n, base_y_n;
    logic               prev_seq;
    logic               refresh;

    assign w4   = entry_words[4];
    assign w6   = entry_words[6];
    assign in_x = entry_words[6][11:0];
    assign in_y = entry_words[7][11:0];

    // scroll seen by this entry, before its own latch bits take effect
    assign scroll_x = w6[15] ? '0 : master_x + (w6[14] ? '0 : extra_x);
    assign scroll_y = w6[15] ? '0 : master_y + (w6[14] ? '0 : extra_y);

    // base moves only on the first entry of a sequence
    assign refresh  = w4[11] & ~prev_seq;
    assign base_x_n = refresh ? in_x + scroll_x : base_x;
    assign base_y_n = refresh ? in_y + scroll_y : base_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            master_x  <= '0;
            master_y  <= '0;
            extra_x   <= '0;
            extra_y   <= '0;
            base_x    <= '0;
            base_y    <= '0;
            prev_seq  <= 1'b0;
            pos_x     <= '0;
            pos_y     <= '0;
            color     <= '0;
            in_bounds <= 1'b0;
        end else begin
            if (eval) begin
                if (w6[13]) begin
                    master_x <= in_x;
                    master_y <= in_y;
                end
                if (w6[12]) begin
                    extra_x <= in_x;
                    extra_y <= in_y;
                end
                base_x   <= base_x_n;
                base_y   <= base_y_n;
                prev_seq <= w4[11];

                pos_y <= w4[12] ? pos_y + 12'd16 : base_y_n;
                pos_x <= (w4[14] | w4[15]) ? pos_x + {7'd0, w4[15], 4'd0} : base_x_n;

                // bit 10 keeps the previous colour
                if (!w4[10]) begin
                    color <= w4[7:0];
                end
            end
            if (check) begin
                in_bounds <= (int'(pos_x) <= obj_pkg::X_LIMIT) &&
                             (int'(pos_y) <= obj_pkg::Y_LIMIT);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (eval) begin
            flip_x    <= w4[8];
            tile_code <= entry_words[0][13:0];
        end
    end

endmodule

`default_nettype wire

/* obj/obj_tile_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_tile_shifter (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  load_start,
    input  wire                  load,
    input  wire obj_pkg::fb_word_t tile_data,
    input  wire obj_pkg::coord_t pos_x,
    input  wire obj_pkg::coord_t pos_y,
    input  wire obj_pkg::color_t color,
    input  wire                  flip_x,
    output logic                 word_ready,
    output obj_pkg::fb_word_t    word,
    output obj_pkg::fb_be_t      be,
    output obj_pkg::fb_addr_t    addr,
    output logic                 last,
    input  wire                  take
);

    obj_pkg::pixel_t        pix [16][16];
    obj_pkg::pixel_t [19:0] row_buf;
    obj_pkg::pixel_t [19:0] cur_row;
    logic [3:0]             beat_cnt;
    logic [3:0]             row;
    logic [2:0]             col;
    logic                   last_beat;
    logic                   emit;

    // tile row placed after x[1:0] empty slots, mirrored on flip_x
    function automatic obj_pkg::pixel_t [19:0] build_row(input logic [3:0] r);
        obj_pkg::pixel_t [19:0] slots;
        slots = '0;
        for (int i = 0; i < 16; i++) begin
            slots[i + int'(pos_x[1:0])] = flip_x ? pix[r][15 - i] : pix[r][i];
        end
        return slots;
    endfunction

    assign last_beat = load && (beat_cnt == 4'(obj_pkg::TILE_BEATS - 1));
    // first word leaves on the last beat, the rest on each take
    assign emit      = !load_start && (last_beat || (take && word_ready && !last));
    // row 0 is long since stored when the last beat lands
    assign cur_row   = last_beat ? build_row(4'd0) : row_buf;

    always_ff @(posedge clk) begin
        if (reset || load_start) begin
            beat_cnt   <= '0;
            word_ready <= 1'b0;
            row        <= '0;
            col        <= '0;
            last       <= 1'b0;
        end else begin
            if (load) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (emit) begin
                word_ready <= 1'b1;
                last       <= (row == 4'd15) && (col == 3'd4);
                if (col == 3'd4) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else if (take) begin
                word_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < 16; i++) begin
                pix[beat_cnt][i] <= tile_data[4*i +: 4];
            end
        end

        if (emit) begin
            for (int k = 0; k < 4; k++) begin
                word[16*k +: 16] <= {4'd0, color, cur_row[k]};
                be[2*k +: 2]     <= {2{|cur_row[k]}};
            end
            addr <= {pos_y[7:0], pos_x[8:2]} + {4'd0, row, 4'd0, col};
            if (col == 3'd4) begin
                row_buf <= build_row(row + 1'b1);
            end else begin
                row_buf <= cur_row >> 16;
            end
        end
    end

endmodule

`default_nettype wire

/* obj/obj_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_sequencer (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           frame_start,
    input  wire obj_pkg::entry_idx_t      entry_idx,
    input  wire                           entry_go,
    input  wire                           list_end,
    output logic                          start,
    output logic                          next,
    output obj_pkg::ram_addr_t            ram_addr,
    input  wire obj_pkg::ram_word_t       ram_data,
    output logic                          eval,
    output logic                          check,
    output obj_pkg::ram_word_t [7:0]      entry_words,
    input  wire                           in_bounds,
    input  wire obj_pkg::tile_code_t      tile_code,
    output logic                          tile_read,
    output obj_pkg::tile_code_t           tile_code_out,
    input  wire                           tile_valid,
    output logic                          load_start,
    output logic                          load,
    input  wire                           word_ready,
    input  wire obj_pkg::fb_word_t        word,
    input  wire obj_pkg::fb_be_t          be,
    input  wire obj_pkg::fb_addr_t        addr,
    input  wire                           last,
    output logic                          take,
    output logic                          fb_write,
    input  wire                           fb_busy,
    output obj_pkg::fb_addr_t             fb_addr,
    output obj_pkg::fb_word_t             fb_data,
    output obj_pkg::fb_be_t               fb_be,
    output logic                          busy
);

    obj_pkg::obj_state_t state;
    logic [3:0]          rd_cnt;
    logic [3:0]          rd_prev;
    logic                draw_ok;

    // word k is addressed at rd_cnt k and returns at rd_cnt k+1
    assign rd_prev  = rd_cnt - 4'd1;
    assign ram_addr = {2'b00, entry_idx, rd_cnt[2:0]};

    assign draw_ok = (tile_code != '0) && in_bounds;

    assign start      = frame_start;
    assign next       = (state == obj_pkg::ST_READ) && (rd_cnt == 4'd8);
    assign eval       = state == obj_pkg::ST_EVAL;
    assign check      = state == obj_pkg::ST_CHECK;
    assign tile_read  = (state == obj_pkg::ST_TILE_REQ) && draw_ok;
    assign load_start = tile_read;
    assign tile_code_out = tile_code;
    assign load       = tile_valid && (state == obj_pkg::ST_TILE_WAIT);
    assign fb_write   = state == obj_pkg::ST_DRAW_WRITE;
    assign take       = fb_write && !fb_busy;
    assign busy       = state != obj_pkg::ST_IDLE;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= obj_pkg::ST_IDLE;
            rd_cnt <= '0;
        end else if (frame_start) begin
            // a new frame abandons whatever the pass was doing
            state <= obj_pkg::ST_READ_START;
        end else begin
            case (state)
                obj_pkg::ST_IDLE: begin
                    state <= obj_pkg::ST_IDLE;
                end
                obj_pkg::ST_READ_START: begin
                    if (list_end) begin
                        state <= obj_pkg::ST_IDLE;
                    end else if (entry_go) begin
                        rd_cnt <= '0;
                        state  <= obj_pkg::ST_READ;
                    end
                end
                obj_pkg::ST_READ: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == 4'd8) begin
                        state <= obj_pkg::ST_EVAL;
                    end
                end
                obj_pkg::ST_EVAL: begin
                    state <= obj_pkg::ST_CHECK;
                end
                obj_pkg::ST_CHECK: begin
                    state <= obj_pkg::ST_TILE_REQ;
                end
                obj_pkg::ST_TILE_REQ: begin
                    state <= draw_ok ? obj_pkg::ST_TILE_WAIT : obj_pkg::ST_READ_START;
                end
                obj_pkg::ST_TILE_WAIT: begin
                    if (word_ready) begin
                        state <= obj_pkg::ST_DRAW_WAIT;
                    end
                end
                obj_pkg::ST_DRAW_WAIT: begin
                    if (word_ready) begin
                        state <= obj_pkg::ST_DRAW_WRITE;
                    end
                end
                obj_pkg::ST_DRAW_WRITE: begin
                    // write held until the framebuffer takes it
                    if (!fb_busy) begin
                        state <= last ? obj_pkg::ST_READ_START : obj_pkg::ST_DRAW_WAIT;
                    end
                end
                default: begin
                    state <= obj_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == obj_pkg::ST_READ) && (rd_cnt != 4'd0)) begin
            entry_words[rd_prev[2:0]] <= ram_data;
        end
        if ((state == obj_pkg::ST_DRAW_WAIT) && word_ready) begin
            fb_addr <= addr;
            fb_data <= word;
            fb_be   <= be;
        end
    end

endmodule

`default_nettype wire

/* obj/obj_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_engine #(
    parameter int ENTRY_COUNT = 835,
    parameter int PACE_SHIFT  = 8
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      frame_start,
    output obj_pkg::ram_addr_t       ram_addr,
    input  wire obj_pkg::ram_word_t  ram_data,
    output logic                     tile_read,
    output obj_pkg::tile_code_t      tile_code,
    input  wire                      tile_valid,
    input  wire obj_pkg::fb_word_t   tile_data,
    output logic                     fb_write,
    input  wire                      fb_busy,
    output obj_pkg::fb_addr_t        fb_addr,
    output obj_pkg::fb_word_t        fb_data,
    output obj_pkg::fb_be_t          fb_be,
    output logic                     busy
);

    obj_pkg::entry_idx_t      entry_idx;
    logic                     entry_go;
    logic                     list_end;
    logic                     start;
    logic                     next;
    logic                     eval;
    logic                     check;
    obj_pkg::ram_word_t [7:0] entry_words;
    obj_pkg::coord_t          pos_x;
    obj_pkg::coord_t          pos_y;
    obj_pkg::color_t          color;
    logic                     flip_x;
    obj_pkg::tile_code_t      eval_tile_code;
    logic                     in_bounds;
    logic                     load_start;
    logic                     load;
    logic                     word_ready;
    obj_pkg::fb_word_t        word;
    obj_pkg::fb_be_t          be;
    obj_pkg::fb_addr_t        addr;
    logic                     last;
    logic                     take;

    obj_pacer #(
        .ENTRY_COUNT (ENTRY_COUNT),
        .PACE_SHIFT  (PACE_SHIFT)
    ) u_pacer (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .next      (next),
        .entry_idx (entry_idx),
        .entry_go  (entry_go),
        .list_end  (list_end)
    );

    obj_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .frame_start   (frame_start),
        .entry_idx     (entry_idx),
        .entry_go      (entry_go),
        .list_end      (list_end),
        .start         (start),
        .next          (next),
        .ram_addr      (ram_addr),
        .ram_data      (ram_data),
        .eval          (eval),
        .check         (check),
        .entry_words   (entry_words),
        .in_bounds     (in_bounds),
        .tile_code     (eval_tile_code),
        .tile_read     (tile_read),
        .tile_code_out (tile_code),
        .tile_valid    (tile_valid),
        .load_start    (load_start),
        .load          (load),
        .word_ready    (word_ready),
        .word          (word),
        .be            (be),
        .addr          (addr),
        .last          (last),
        .take          (take),
        .fb_write      (fb_write),
        .fb_busy       (fb_busy),
        .fb_addr       (fb_addr),
        .fb_data       (fb_data),
        .fb_be         (fb_be),
        .busy          (busy)
    );

    obj_entry_eval u_entry_eval (
        .clk         (clk),
        .reset       (reset),
        .eval        (eval),
        .check       (check),
        .entry_words (entry_words),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .color       (color),
        .flip_x      (flip_x),
        .tile_code   (eval_tile_code),
        .in_bounds   (in_bounds)
    );

    obj_tile_shifter u_tile_shifter (
        .clk        (clk),
        .reset      (reset),
        .load_start (load_start),
        .load       (load),
        .tile_data  (tile_data),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .color      (color),
        .flip_x     (flip_x),
        .word_ready (word_ready),
        .word       (word),
        .be         (be),
        .addr       (addr),
        .last       (last),
        .take       (take)
    );

endmodule

`default_nettype wire

/* testbench/obj_sequencer_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_sequencer_properties (
    input wire                    clk,
    input wire                    reset,
    input wire                    tile_read,
    input wire                    fb_write,
    input wire                    fb_busy,
    input wire                    busy,
    input wire obj_pkg::fb_addr_t fb_addr,
    input wire obj_pkg::fb_word_t fb_data,
    input wire obj_pkg::fb_be_t   fb_be
);

    int fail_count = 0;

    // a stalled write keeps address, data and enables until accepted
    write_held: assert property (@(posedge clk) disable iff (reset)
        fb_write && fb_busy |=> fb_write && $stable(fb_addr) && $stable(fb_data) && $stable(fb_be))
    else begin
        fail_count++;
        $error("framebuffer write changed while fb_busy was high");
    end

    tile_read_pulse: assert property (@(posedge clk) disable iff (reset)
        tile_read |=> !tile_read)
    else begin
        fail_count++;
        $error("tile_read held for more than one cycle");
    end

    // sequencer sits in idle right after reset
    idle_after_reset: assert property (@(posedge clk)
        reset |=> !busy && !tile_read && !fb_write)
    else begin
        fail_count++;
        $error("controls active after reset");
    end

endmodule

`default_nettype wire

/* testbench/obj_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module obj_checker #(
    parameter int ENTRY_COUNT = 24
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      frame_start,
    input  wire                      busy,
    input  wire                      fb_write,
    input  wire                      fb_busy,
    input  wire obj_pkg::fb_addr_t   fb_addr,
    input  wire obj_pkg::fb_word_t   fb_data,
    input  wire obj_pkg::fb_be_t     fb_be,
    input  wire obj_pkg::ram_word_t  ram [256],
    input  wire obj_pkg::fb_word_t   rom [1024],
    output int                       errors,
    output int                       pass_writes,
    output logic [63:0]              pass_sig
);

    // {addr, be, data} per expected write
    logic [86:0]     expect_q [$];
    logic [86:0]     exp_w;
    obj_pkg::coord_t master_x, master_y;
    obj_pkg::coord_t extra_x, extra_y;
    obj_pkg::coord_t base_x, base_y;
    obj_pkg::coord_t pos_x, pos_y;
    obj_pkg::color_t color;
    logic            prev_seq;
    logic            busy_q;
    int              count;
    logic [63:0]     sig;

    task automatic push_tile(input obj_pkg::coord_t x, input obj_pkg::coord_t y,
                             input logic flip, input obj_pkg::tile_code_t code);
        obj_pkg::pixel_t   slots [20];
        obj_pkg::fb_word_t row_pix;
        obj_pkg::fb_word_t data;
        obj_pkg::fb_be_t   be;
        obj_pkg::fb_addr_t addr;
        for (int r = 0; r < 16; r++) begin
            row_pix = rom[{code[5:0], 4'(r)}];
            foreach (slots[s]) begin
                slots[s] = '0;
            end
            // pixels land after x[1:0] empty slots
            for (int i = 0; i < 16; i++) begin
                slots[i + int'(x[1:0])] = row_pix[4 * (flip ? 15 - i : i) +: 4];
            end
            for (int c = 0; c < 5; c++) begin
                for (int k = 0; k < 4; k++) begin
                    data[16*k +: 16] = {4'd0, color, slots[4*c + k]};
                    be[2*k +: 2]     = {2{|slots[4*c + k]}};
                end
                addr = {y[7:0], x[8:2]} + obj_pkg::fb_addr_t'(r * 128 + c);
                expect_q.push_back({addr, be, data});
            end
        end
    endtask

    // latches carry over from pass to pass, as in hardware
    task automatic build_pass();
        obj_pkg::ram_word_t w0;
        obj_pkg::ram_word_t w4;
        obj_pkg::ram_word_t w6;
        obj_pkg::coord_t    in_x, in_y;
        obj_pkg::coord_t    scroll_x, scroll_y;
        expect_q.delete();
        for (int n = 0; n < ENTRY_COUNT; n++) begin
            w0   = ram[8*n];
            w4   = ram[8*n + 4];
            w6   = ram[8*n + 6];
            in_x = w6[11:0];
            in_y = ram[8*n + 7][11:0];
            scroll_x = w6[15] ? '0 : master_x + (w6[14] ? 12'd0 : extra_x);
            scroll_y = w6[15] ? '0 : master_y + (w6[14] ? 12'd0 : extra_y);
            if (w4[11] && !prev_seq) begin
                base_x = in_x + scroll_x;
                base_y = in_y + scroll_y;
            end
            if (w6[13]) begin
                master_x = in_x;
                master_y = in_y;
            end
            if (w6[12]) begin
                extra_x = in_x;
                extra_y = in_y;
            end
            prev_seq = w4[11];
            pos_y = w4[12] ? pos_y + 12'd16 : base_y;
            pos_x = (w4[14] || w4[15]) ? pos_x + (w4[15] ? 12'd16 : 12'd0) : base_x;
            if (!w4[10]) begin
                color = w4[7:0];
            end
            if ((w0[13:0] != '0) && (int'(pos_x) <= obj_pkg::X_LIMIT) &&
                (int'(pos_y) <= obj_pkg::Y_LIMIT)) begin
                push_tile(pos_x, pos_y, w4[8], w0[13:0]);
            end
        end
    endtask

    always @(posedge clk) begin
        busy_q <= busy;
        if (reset) begin
            master_x = '0;
            master_y = '0;
            extra_x  = '0;
            extra_y  = '0;
            base_x   = '0;
            base_y   = '0;
            pos_x    = '0;
            pos_y    = '0;
            color    = '0;
            prev_seq = 1'b0;
            errors   = 0;
            count    = 0;
            sig      = '0;
            expect_q.delete();
        end else begin
            if (frame_start) begin
                build_pass();
                count = 0;
                sig   = '0;
            end
            if (fb_write && !fb_busy) begin
                count++;
                sig = {sig[62:0], sig[63]} ^ fb_data ^ {fb_addr, fb_be, 41'd0};
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("** Error at %0t: unexpected write addr %h be %h data %h",
                             $time, fb_addr, fb_be, fb_data);
                end else begin
                    exp_w = expect_q.pop_front();
                    if (exp_w != {fb_addr, fb_be, fb_data}) begin
                        errors++;
                        $display("** Error at %0t: write %0d got addr %h be %h data %h",
                                 $time, count, fb_addr, fb_be, fb_data);
                        $display("** Error at %0t: expected addr %h be %h data %h",
                                 $time, exp_w[86:72], exp_w[71:64], exp_w[63:0]);
                    end
                end
            end
            if (busy_q && !busy) begin
                if (expect_q.size() != 0) begin
                    errors++;
                    $display("** Error at %0t: pass ended with %0d expected writes missing",
                             $time, expect_q.size());
                end
                pass_writes = count;
                pass_sig    = sig;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_obj_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_obj_engine;

    localparam int ENTRY_COUNT  = 24;
    localparam int PASS_TIMEOUT = 40000;

    logic                clk;
    logic                reset;
    logic                frame_start;
    obj_pkg::ram_addr_t  ram_addr;
    obj_pkg::ram_word_t  ram_data = '0;
    logic                tile_read;
    obj_pkg::tile_code_t tile_code;
    logic                tile_valid = 1'b0;
    obj_pkg::fb_word_t   tile_data = '0;
    logic                fb_write;
    logic                fb_busy = 1'b0;
    obj_pkg::fb_addr_t   fb_addr;
    obj_pkg::fb_word_t   fb_data;
    obj_pkg::fb_be_t     fb_be;
    logic                busy;

    obj_pkg::ram_word_t  sprite_ram [256];
    obj_pkg::fb_word_t   tile_rom [1024];
    obj_pkg::tile_code_t rom_code;
    logic [3:0]          rom_row;
    int                  rom_left;
    int                  tb_errors;
    logic                timed_out;
    int                  checker_errors;
    int                  pass_writes;
    logic [63:0]         pass_sig;
    int                  first_writes;
    logic [63:0]         first_sig;

    obj_engine #(
        .ENTRY_COUNT (ENTRY_COUNT),
        .PACE_SHIFT  (6)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .ram_addr    (ram_addr),
        .ram_data    (ram_data),
        .tile_read   (tile_read),
        .tile_code   (tile_code),
        .tile_valid  (tile_valid),
        .tile_data   (tile_data),
        .fb_write    (fb_write),
        .fb_busy     (fb_busy),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .fb_be       (fb_be),
        .busy        (busy)
    );

    obj_checker #(
        .ENTRY_COUNT (ENTRY_COUNT)
    ) u_checker (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .busy        (busy),
        .fb_write    (fb_write),
        .fb_busy     (fb_busy),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .fb_be       (fb_be),
        .ram         (sprite_ram),
        .rom         (tile_rom),
        .errors      (checker_errors),
        .pass_writes (pass_writes),
        .pass_sig    (pass_sig)
    );

    bind obj_sequencer obj_sequencer_properties u_seq_props (
        .clk       (clk),
        .reset     (reset),
        .tile_read (tile_read),
        .fb_write  (fb_write),
        .fb_busy   (fb_busy),
        .busy      (busy),
        .fb_addr   (fb_addr),
        .fb_data   (fb_data),
        .fb_be     (fb_be)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // index is {code[5:0], row}
    function automatic obj_pkg::fb_word_t tile_hash(input logic [9:0] a);
        logic [63:0] h;
        h = 64'h9e37_79b9_7f4a_7c15 * {54'd0, a + 10'd1};
        h = h ^ (h >> 29);
        return h & {h[23:0], h[63:24]};
    endfunction

    task automatic fill_memories();
        obj_pkg::ram_word_t w4;
        obj_pkg::ram_word_t w6;
        obj_pkg::ram_word_t w7;
        for (int a = 0; a < 1024; a++) begin
            tile_rom[a] = tile_hash(10'(a));
        end
        for (int a = 0; a < 256; a++) begin
            sprite_ram[a] = 16'($urandom);
        end
        for (int n = 0; n < 32; n++) begin
            sprite_ram[8*n] = (($urandom % 5) == 0) ? '0 : 16'($urandom_range(1, 63));
            w4     = sprite_ram[8*n + 4];
            w4[10] = ($urandom % 3) == 0;
            w4[11] = ($urandom % 2) == 0;
            w4[12] = ($urandom % 4) == 0;
            w4[14] = ($urandom % 4) == 0;
            w4[15] = ($urandom % 5) == 0;
            w6     = {4'b0000, 12'($urandom_range(0, 500))};
            w6[15] = ($urandom % 4) == 0;
            w6[14] = ($urandom % 3) == 0;
            w6[13] = ($urandom % 6) == 0;
            w6[12] = ($urandom % 6) == 0;
            w7     = 16'($urandom_range(0, 250));
            if (n == 0) begin
                // no draw, clears the sequence bit and latches both scrolls
                sprite_ram[0] = '0;
                w4[15:10]     = 6'b000000;
                w6            = {4'b0011, 12'($urandom_range(0, 40))};
                w7            = 16'($urandom_range(0, 20));
            end else if (n == 1) begin
                // fresh sequence base, so every pass places entries the same way
                w4[15:11] = 5'b00001;
            end
            sprite_ram[8*n + 4] = w4;
            sprite_ram[8*n + 6] = w6;
            sprite_ram[8*n + 7] = w7;
        end
    endtask

    always @(posedge clk) begin
        ram_data <= sprite_ram[ram_addr[7:0]];
        fb_busy  <= !reset && (($urandom % 4) == 0);
    end

    // tile ROM replies row by row with random idle gaps
    always @(posedge clk) begin
        if (reset) begin
            tile_valid <= 1'b0;
            rom_left   <= 0;
        end else if (tile_read) begin
            rom_code   <= tile_code;
            rom_row    <= '0;
            rom_left   <= obj_pkg::TILE_BEATS;
            tile_valid <= 1'b0;
        end else if ((rom_left != 0) && (($urandom % 3) != 0)) begin
            tile_valid <= 1'b1;
            tile_data  <= tile_rom[{rom_code[5:0], rom_row}];
            rom_row    <= rom_row + 1'b1;
            rom_left   <= rom_left - 1;
        end else begin
            tile_valid <= 1'b0;
        end
    end

    task automatic run_pass();
        int cycles;
        @(posedge clk);
        frame_start <= 1'b1;
        @(posedge clk);
        frame_start <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (busy && (cycles < PASS_TIMEOUT));
        if (busy) begin
            timed_out = 1'b1;
            $display("timeout: busy still high after %0d cycles", PASS_TIMEOUT);
        end else if (cycles == 1) begin
            tb_errors++;
            $display("busy did not rise after frame_start");
        end
        // let the checker close the pass
        repeat (2) @(posedge clk);
    endtask

    initial begin
        void'($urandom(62598));
        reset       <= 1'b1;
        frame_start <= 1'b0;
        tb_errors   = 0;
        timed_out   = 1'b0;
        fill_memories();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (busy || tile_read || fb_write) begin
            tb_errors++;
            $display("** Error at %0t: controls not low after reset", $time);
        end

        run_pass();
        first_writes = pass_writes;
        first_sig    = pass_sig;
        if (!timed_out) begin
            if (first_writes == 0) begin
                tb_errors++;
                $display("first pass produced no framebuffer writes");
            end
            run_pass();
            if (!timed_out && ((pass_writes != first_writes) || (pass_sig != first_sig))) begin
                tb_errors++;
                $display("** Error at %0t: second pass gave %0d writes, first pass %0d",
                         $time, pass_writes, first_writes);
            end
        end

        $display("error counts: checker %0d, testbench %0d, assertions %0d",
                 checker_errors, tb_errors, u_dut.u_sequencer.u_seq_props.fail_count);
        if (timed_out || (tb_errors != 0) || (checker_errors != 0) ||
            (u_dut.u_sequencer.u_seq_props.fail_count != 0)) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/obj_pkg.sv
logic/obj_pacer.sv
obj/obj_entry_eval.sv
obj/obj_tile_shifter.sv
obj/obj_sequencer.sv
obj/obj_engine.sv
testbench/obj_sequencer_properties.sv
testbench/obj_checker.sv
testbench/tb_obj_engine.sv

/* Makefile */
TOP := tb_obj_engine
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): src.f $(shell cat src.f)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
